// File: periph_pkg.sv
package periph_pkg;

    // ----------------------------------------------------------
    // Sizes
    // ----------------------------------------------------------
    localparam int APB_AW         = 32;
    localparam int APB_DW         = 32;
    localparam int NUM_SOURCES    = 5;
    localparam int NUM_TARGETS    = 2;
    localparam int NUM_TIMERS     = 2;
    localparam int PRIO_W         = 3;
    localparam int SRC_ID_W       = 3;
    // Timer channels sit above the external sources
    localparam int TIMER_IRQ_BASE = 3;

    typedef logic [APB_AW-1:0]      apb_addr_t;
    typedef logic [APB_DW-1:0]      apb_data_t;
    typedef logic [PRIO_W-1:0]      prio_t;
    typedef logic [SRC_ID_W-1:0]    src_id_t;
    typedef logic [NUM_SOURCES-1:0] src_vec_t;
    typedef logic [3:0]             region_t;

    // ----------------------------------------------------------
    // Address map
    // ----------------------------------------------------------
    // Region number taken from paddr[15:12]
    localparam region_t REGION_PLIC  = 4'd0;
    localparam region_t REGION_TIMER = 4'd1;

    localparam logic [11:0] PLIC_PRIO_OFS  = 12'h000;
    localparam logic [11:0] PLIC_PEND_OFS  = 12'h100;
    localparam logic [11:0] PLIC_EN_OFS    = 12'h200;
    localparam logic [11:0] PLIC_THR_OFS   = 12'h300;
    localparam logic [11:0] PLIC_CLAIM_OFS = 12'h400;

    localparam int          TMR_STRIDE   = 'h10;
    localparam logic [3:0]  TMR_CTRL_OFS = 4'h0;
    localparam logic [3:0]  TMR_CNT_OFS  = 4'h4;
    localparam logic [3:0]  TMR_CMP_OFS  = 4'h8;
    localparam logic [3:0]  TMR_STAT_OFS = 4'hC;

    localparam apb_data_t ERR_RDATA = 32'hDEADBEEF;

endpackage

// File: timer_channel.sv
module timer_channel
    import periph_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      enable_i,
    input  apb_data_t cmp_i,
    input  logic      cnt_we_i,
    input  apb_data_t cnt_wdata_i,
    input  logic      stat_clr_i,
    output apb_data_t cnt_o,
    output logic      irq_o
);

    apb_data_t cnt_q;
    logic      stat_q;
    logic      match;

    assign match = enable_i && (cnt_q == cmp_i);

    // Period is cmp + 1 cycles
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (cnt_we_i) begin
            cnt_q <= cnt_wdata_i;
        end else if (match) begin
            cnt_q <= '0;
        end else if (enable_i) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Sticky until software clears it
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            stat_q <= 1'b0;
        end else if (stat_clr_i) begin
            stat_q <= 1'b0;
        end else if (match) begin
            stat_q <= 1'b1;
        end
    end

    assign cnt_o = cnt_q;
    assign irq_o = stat_q;

endmodule

// File: apb_timer.sv
module apb_timer
    import periph_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  apb_addr_t             paddr_i,
    input  apb_data_t             pwdata_i,
    output apb_data_t             prdata_o,
    output logic [NUM_TIMERS-1:0] irq_o
);

    logic      [NUM_TIMERS-1:0] en_q;
    apb_data_t [NUM_TIMERS-1:0] cmp_q;
    apb_data_t [NUM_TIMERS-1:0] cnt;
    logic      [NUM_TIMERS-1:0] chan_hit;
    logic      [NUM_TIMERS-1:0] cnt_we;
    logic      [NUM_TIMERS-1:0] stat_clr;
    logic [11:0]                ofs;
    logic [3:0]                 reg_ofs;
    logic                       rd_en;
    logic                       wr_en;

    assign ofs     = paddr_i[11:0];
    assign reg_ofs = paddr_i[3:0];
    assign rd_en   = psel_i & penable_i & ~pwrite_i;
    assign wr_en   = psel_i & penable_i & pwrite_i;

    for (genvar c = 0; c < NUM_TIMERS; c++) begin : gen_chan
        assign chan_hit[c] = (ofs >= 12'(c * TMR_STRIDE)) &&
                             (ofs < 12'((c + 1) * TMR_STRIDE));
        assign cnt_we[c]   = wr_en & chan_hit[c] & (reg_ofs == TMR_CNT_OFS);
        // Write one to clear
        assign stat_clr[c] = wr_en & chan_hit[c] & (reg_ofs == TMR_STAT_OFS) & pwdata_i[0];

        timer_channel i_channel (
            .clk_i       ( clk_i       ),
            .rst_n_i     ( rst_n_i     ),
            .enable_i    ( en_q[c]     ),
            .cmp_i       ( cmp_q[c]    ),
            .cnt_we_i    ( cnt_we[c]   ),
            .cnt_wdata_i ( pwdata_i    ),
            .stat_clr_i  ( stat_clr[c] ),
            .cnt_o       ( cnt[c]      ),
            .irq_o       ( irq_o[c]    )
        );
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            en_q  <= '0;
            cmp_q <= '0;
        end else if (wr_en) begin
            for (int c = 0; c < NUM_TIMERS; c++) begin
                if (chan_hit[c] && reg_ofs == TMR_CTRL_OFS) begin
                    en_q[c] <= pwdata_i[0];
                end
                if (chan_hit[c] && reg_ofs == TMR_CMP_OFS) begin
                    cmp_q[c] <= pwdata_i;
                end
            end
        end
    end

    // Read routing
    always_comb begin
        prdata_o = '0;
        for (int c = 0; c < NUM_TIMERS; c++) begin
            if (rd_en && chan_hit[c]) begin
                case (reg_ofs)
                    TMR_CTRL_OFS: prdata_o = apb_data_t'(en_q[c]);
                    TMR_CNT_OFS:  prdata_o = cnt[c];
                    TMR_CMP_OFS:  prdata_o = cmp_q[c];
                    TMR_STAT_OFS: prdata_o = apb_data_t'(irq_o[c]);
                    default:      prdata_o = '0;
                endcase
            end
        end
    end

endmodule

// File: plic_gateway.sv
module plic_gateway
    import periph_pkg::*;
(
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic level_i,
    input  logic claim_i,
    input  logic complete_i,
    output logic pending_o
);

    logic pending_q;
    logic in_service_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pending_q    <= 1'b0;
            in_service_q <= 1'b0;
        end else begin
            // Source stays masked while in service
            if (claim_i) begin
                pending_q <= 1'b0;
            end else if (level_i && !in_service_q) begin
                pending_q <= 1'b1;
            end

            if (claim_i) begin
                in_service_q <= 1'b1;
            end else if (complete_i) begin
                in_service_q <= 1'b0;
            end
        end
    end

    assign pending_o = pending_q;

endmodule

// File: plic_target.sv
module plic_target
    import periph_pkg::*;
(
    input  src_vec_t                pending_i,
    input  src_vec_t                enable_i,
    input  prio_t [NUM_SOURCES-1:0] prio_i,
    input  prio_t                   threshold_i,
    output src_id_t                 claim_id_o,
    output logic                    irq_o
);

    prio_t   best_prio;
    src_id_t best_id;

    // ----------------------------------------------------------
    // Highest priority search
    // ----------------------------------------------------------
    always_comb begin
        best_prio = '0;
        best_id   = '0;
        for (int i = 0; i < NUM_SOURCES; i++) begin
            // Strict compare keeps lowest index on a tie
            if (pending_i[i] && enable_i[i] && (prio_i[i] > best_prio)) begin
                best_prio = prio_i[i];
                best_id   = src_id_t'(i + 1);
            end
        end
    end

    // Priority 0 never wins, so best_prio > threshold implies a source
    assign irq_o      = (best_prio > threshold_i);
    assign claim_id_o = irq_o ? best_id : '0;

endmodule

// File: plic_core.sv
module plic_core
    import periph_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  apb_addr_t              paddr_i,
    input  apb_data_t              pwdata_i,
    output apb_data_t              prdata_o,
    input  src_vec_t               irq_sources_i,
    output logic [NUM_TARGETS-1:0] irq_o
);

    prio_t    [NUM_SOURCES-1:0] prio_q;
    src_vec_t [NUM_TARGETS-1:0] en_q;
    prio_t    [NUM_TARGETS-1:0] thr_q;
    src_id_t  [NUM_TARGETS-1:0] claim_id;
    src_vec_t                   pending;
    src_vec_t                   claim;
    src_vec_t                   complete;
    logic                       rd_en;
    logic                       wr_en;
    logic [3:0]                 page;
    logic [5:0]                 idx;

    assign rd_en = psel_i & penable_i & ~pwrite_i;
    assign wr_en = psel_i & penable_i & pwrite_i;
    assign page  = paddr_i[11:8];
    assign idx   = paddr_i[7:2];

    // ----------------------------------------------------------
    // Configuration registers
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            prio_q <= '0;
            en_q   <= '0;
            thr_q  <= '0;
        end else if (wr_en) begin
            for (int i = 0; i < NUM_SOURCES; i++) begin
                if (page == PLIC_PRIO_OFS[11:8] && int'(idx) == i) begin
                    prio_q[i] <= pwdata_i[PRIO_W-1:0];
                end
            end
            for (int t = 0; t < NUM_TARGETS; t++) begin
                if (int'(idx) == t) begin
                    if (page == PLIC_EN_OFS[11:8]) begin
                        en_q[t] <= pwdata_i[NUM_SOURCES-1:0];
                    end
                    if (page == PLIC_THR_OFS[11:8]) begin
                        thr_q[t] <= pwdata_i[PRIO_W-1:0];
                    end
                end
            end
        end
    end

    // Claim on read, complete on write of a valid id
    always_comb begin
        claim    = '0;
        complete = '0;
        for (int t = 0; t < NUM_TARGETS; t++) begin
            if (page == PLIC_CLAIM_OFS[11:8] && int'(idx) == t) begin
                for (int i = 0; i < NUM_SOURCES; i++) begin
                    if (rd_en && claim_id[t] == src_id_t'(i + 1)) begin
                        claim[i] = 1'b1;
                    end
                    if (wr_en && pwdata_i == apb_data_t'(i + 1)) begin
                        complete[i] = 1'b1;
                    end
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Read mux
    // ----------------------------------------------------------
    always_comb begin
        prdata_o = '0;
        if (rd_en) begin
            case (page)
                PLIC_PRIO_OFS[11:8]: begin
                    for (int i = 0; i < NUM_SOURCES; i++) begin
                        if (int'(idx) == i) begin
                            prdata_o = apb_data_t'(prio_q[i]);
                        end
                    end
                end
                PLIC_PEND_OFS[11:8]: begin
                    if (idx == '0) begin
                        prdata_o = apb_data_t'(pending);
                    end
                end
                PLIC_EN_OFS[11:8], PLIC_THR_OFS[11:8], PLIC_CLAIM_OFS[11:8]: begin
                    for (int t = 0; t < NUM_TARGETS; t++) begin
                        if (int'(idx) == t) begin
                            if (page == PLIC_EN_OFS[11:8]) begin
                                prdata_o = apb_data_t'(en_q[t]);
                            end else if (page == PLIC_THR_OFS[11:8]) begin
                                prdata_o = apb_data_t'(thr_q[t]);
                            end else begin
                                prdata_o = apb_data_t'(claim_id[t]);
                            end
                        end
                    end
                end
                default: prdata_o = '0;
            endcase
        end
    end

    for (genvar i = 0; i < NUM_SOURCES; i++) begin : gen_gateway
        plic_gateway i_gateway (
            .clk_i      ( clk_i            ),
            .rst_n_i    ( rst_n_i          ),
            .level_i    ( irq_sources_i[i] ),
            .claim_i    ( claim[i]         ),
            .complete_i ( complete[i]      ),
            .pending_o  ( pending[i]       )
        );
    end

    for (genvar t = 0; t < NUM_TARGETS; t++) begin : gen_target
        plic_target i_target (
            .pending_i   ( pending     ),
            .enable_i    ( en_q[t]     ),
            .prio_i      ( prio_q      ),
            .threshold_i ( thr_q[t]    ),
            .claim_id_o  ( claim_id[t] ),
            .irq_o       ( irq_o[t]    )
        );
    end

endmodule

// File: apb_decoder.sv
module apb_decoder
    import periph_pkg::*;
(
    input  logic      psel_i,
    input  logic      penable_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t prdata_plic_i,
    input  apb_data_t prdata_tmr_i,
    output logic      psel_plic_o,
    output logic      psel_tmr_o,
    output apb_data_t prdata_o,
    output logic      pslverr_o
);

    region_t region;
    logic    hit_plic;
    logic    hit_tmr;
    logic    access;

    assign region   = paddr_i[15:12];
    assign hit_plic = (region == REGION_PLIC);
    assign hit_tmr  = (region == REGION_TIMER);
    assign access   = psel_i & penable_i;

    assign psel_plic_o = psel_i & hit_plic;
    assign psel_tmr_o  = psel_i & hit_tmr;

    // ----------------------------------------------------------
    // Response mux, quiet outside the access cycle
    // ----------------------------------------------------------
    always_comb begin
        prdata_o  = '0;
        pslverr_o = 1'b0;
        if (access) begin
            if (hit_plic) begin
                prdata_o = prdata_plic_i;
            end else if (hit_tmr) begin
                prdata_o = prdata_tmr_i;
            end else begin
                // Default error responder
                prdata_o  = ERR_RDATA;
                pslverr_o = 1'b1;
            end
        end
    end

endmodule

// File: periph_top.sv
module periph_top
    import periph_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  apb_addr_t                 paddr_i,
    input  apb_data_t                 pwdata_i,
    input  logic [TIMER_IRQ_BASE-1:0] irq_src_i,
    output apb_data_t                 prdata_o,
    output logic                      pslverr_o,
    output logic [NUM_TARGETS-1:0]    irq_o
);

    logic                  psel_plic;
    logic                  psel_tmr;
    apb_data_t             prdata_plic;
    apb_data_t             prdata_tmr;
    logic [NUM_TIMERS-1:0] tmr_irq;
    src_vec_t              irq_sources;

    // Timer compare interrupts above the external levels
    assign irq_sources = {tmr_irq, irq_src_i};

    apb_decoder i_decoder (
        .psel_i        ( psel_i      ),
        .penable_i     ( penable_i   ),
        .paddr_i       ( paddr_i     ),
        .prdata_plic_i ( prdata_plic ),
        .prdata_tmr_i  ( prdata_tmr  ),
        .psel_plic_o   ( psel_plic   ),
        .psel_tmr_o    ( psel_tmr    ),
        .prdata_o      ( prdata_o    ),
        .pslverr_o     ( pslverr_o   )
    );

    plic_core i_plic (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .psel_i        ( psel_plic   ),
        .penable_i     ( penable_i   ),
        .pwrite_i      ( pwrite_i    ),
        .paddr_i       ( paddr_i     ),
        .pwdata_i      ( pwdata_i    ),
        .prdata_o      ( prdata_plic ),
        .irq_sources_i ( irq_sources ),
        .irq_o         ( irq_o       )
    );

    apb_timer i_timer (
        .clk_i     ( clk_i      ),
        .rst_n_i   ( rst_n_i    ),
        .psel_i    ( psel_tmr   ),
        .penable_i ( penable_i  ),
        .pwrite_i  ( pwrite_i   ),
        .paddr_i   ( paddr_i    ),
        .pwdata_i  ( pwdata_i   ),
        .prdata_o  ( prdata_tmr ),
        .irq_o     ( tmr_irq    )
    );

endmodule

// File: periph_checker.sv
module periph_checker
    import periph_pkg::*;
(
    input logic                   clk_i,
    input logic                   rst_n_i,
    input logic                   psel_i,
    input logic                   penable_i,
    input apb_data_t              prdata_o,
    input logic                   pslverr_o,
    input logic [NUM_TARGETS-1:0] irq_o
);

    timeunit 1ns;
    timeprecision 100ps;

    logic access;

    assign access = psel_i & penable_i;

    // Error response belongs to the access cycle only
    a_err_access: assert property (@(posedge clk_i) pslverr_o |-> access)
        else $error("pslverr_o high outside an access cycle");

    a_rdata_idle: assert property (@(posedge clk_i) !access |-> prdata_o == '0)
        else $error("prdata_o not zero outside an access cycle");

    // Quiet in reset and in the first cycle after it
    a_irq_reset: assert property (@(posedge clk_i) !rst_n_i |=> irq_o == '0)
        else $error("irq_o raised during or right after reset");

endmodule

// File: tb_periph_top.sv
module tb_periph_top
    import periph_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_RDMAX, OP_SRC, OP_IRQ, OP_WIRQ} op_e;

    // For irq entries data is the mask and exp the wanted level
    typedef struct {
        op_e       op;
        apb_addr_t addr;
        apb_data_t data;
        apb_data_t exp;
        logic      err;
    } entry_t;

    localparam int RESET_CYCLES = 16;
    localparam int IRQ_WAIT     = 16;

    // Readback of priorities, enables, thresholds and timer compares
    localparam apb_addr_t RB_ADDR [11] = '{'h000, 'h004, 'h008, 'h00C, 'h010, 'h200,
                                           'h204, 'h300, 'h304, 'h1008, 'h1018};
    localparam apb_data_t RB_WMASK [11] = '{'1, '1, '1, '1, '1, '1, '1, 'h7, 'h7, '1, '1};
    localparam apb_data_t RB_RMASK [11] = '{'h7, 'h7, 'h7, 'h7, 'h7, 'h1F, 'h1F,
                                            '1, '1, '1, '1};

    logic                   clk_i = 1'b0;
    logic                   rst_n_i;
    logic                   psel_i;
    logic                   penable_i;
    logic                   pwrite_i;
    apb_addr_t              paddr_i;
    apb_data_t              pwdata_i;
    logic [2:0]             irq_src_i;
    apb_data_t              prdata_o;
    logic                   pslverr_o;
    logic [NUM_TARGETS-1:0] irq_o;
    entry_t                 stim_q[$];
    int                     cycles = 0;
    int                     cycle_limit = 0;

    always #4 clk_i = ~clk_i;

    periph_top i_dut (.*);

    bind periph_top periph_checker i_checker (.*);

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Run timed out after %0d cycles", cycles);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input apb_data_t got, input apb_data_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got 0x%08h, expected 0x%08h", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic void add_entry(input op_e op, input apb_addr_t addr,
                                      input apb_data_t data, input apb_data_t exp,
                                      input logic err);
        entry_t e;
        e = '{op, addr, data, exp, err};
        stim_q.push_back(e);
    endfunction

    // Setup cycle, then access cycle with the response sampled mid cycle
    task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t data,
                              output apb_data_t rdata, output logic err);
        @(posedge clk_i);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= wr;
        paddr_i   <= addr;
        pwdata_i  <= data;
        @(posedge clk_i);
        penable_i <= 1'b1;
        @(negedge clk_i);
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic wait_for_irq(input logic [1:0] mask, input logic [1:0] want);
        int n;
        n = 0;
        @(negedge clk_i);
        while ((irq_o & mask) != want && n < IRQ_WAIT) begin
            @(negedge clk_i);
            n++;
        end
        if ((irq_o & mask) != want) begin
            $display("irq_o never reached %b under mask %b within %0d cycles", want, mask,
                     IRQ_WAIT);
            abort_run();
        end
    endtask

    task automatic build_table();
        apb_data_t rnd;
        // Unmapped region 5, then mapped accesses
        add_entry(OP_RD, 'h5000, '0, 32'hDEAD_BEEF, 1'b1);
        add_entry(OP_WR, 'h5004, 'h1234, '0, 1'b1);
        add_entry(OP_RD, 'h0100, '0, '0, 1'b0);
        add_entry(OP_RD, 'h1000, '0, '0, 1'b0);
        for (int i = 0; i < 11; i++) begin
            rnd = $urandom & RB_WMASK[i];
            add_entry(OP_WR, RB_ADDR[i], rnd, '0, 1'b0);
            add_entry(OP_RD, RB_ADDR[i], '0, rnd & RB_RMASK[i], 1'b0);
        end
        // Source 1 at priority 2 on target 0
        add_entry(OP_WR, 'h004, 2, '0, 1'b0);
        add_entry(OP_WR, 'h200, 'h02, '0, 1'b0);
        add_entry(OP_WR, 'h300, 0, '0, 1'b0);
        add_entry(OP_WR, 'h204, 0, '0, 1'b0);
        add_entry(OP_SRC, '0, 'b010, '0, 1'b0);
        add_entry(OP_WIRQ, '0, 'b01, 'b01, 1'b0);
        add_entry(OP_RD, 'h400, '0, 2, 1'b0);
        add_entry(OP_IRQ, '0, 'b01, 'b00, 1'b0);
        add_entry(OP_WR, 'h400, 2, '0, 1'b0);
        add_entry(OP_WIRQ, '0, 'b01, 'b01, 1'b0);
        add_entry(OP_SRC, '0, 'b000, '0, 1'b0);
        add_entry(OP_RD, 'h400, '0, 2, 1'b0);
        add_entry(OP_WR, 'h400, 2, '0, 1'b0);
        add_entry(OP_IRQ, '0, 'b01, 'b00, 1'b0);
        // Arbitration between sources 0 and 2
        add_entry(OP_WR, 'h000, 3, '0, 1'b0);
        add_entry(OP_WR, 'h008, 5, '0, 1'b0);
        add_entry(OP_WR, 'h200, 'h05, '0, 1'b0);
        add_entry(OP_SRC, '0, 'b101, '0, 1'b0);
        add_entry(OP_WIRQ, '0, 'b01, 'b01, 1'b0);
        add_entry(OP_RD, 'h400, '0, 3, 1'b0);
        add_entry(OP_WR, 'h400, 3, '0, 1'b0);
        add_entry(OP_WR, 'h000, 5, '0, 1'b0);
        add_entry(OP_WIRQ, '0, 'b01, 'b01, 1'b0);
        add_entry(OP_RD, 'h400, '0, 1, 1'b0);
        add_entry(OP_WR, 'h400, 1, '0, 1'b0);
        add_entry(OP_WR, 'h300, 5, '0, 1'b0);
        add_entry(OP_IRQ, '0, 'b01, 'b00, 1'b0);
        add_entry(OP_SRC, '0, 'b000, '0, 1'b0);
        // Timer channel 1 as source 4 on target 1
        add_entry(OP_WR, 'h010, 1, '0, 1'b0);
        add_entry(OP_WR, 'h204, 'h10, '0, 1'b0);
        add_entry(OP_WR, 'h304, 0, '0, 1'b0);
        add_entry(OP_WR, 'h1018, 20, '0, 1'b0);
        add_entry(OP_WR, 'h1010, 1, '0, 1'b0);
        add_entry(OP_RDMAX, 'h1014, '0, 20, 1'b0);
        add_entry(OP_RDMAX, 'h1014, '0, 20, 1'b0);
        add_entry(OP_RDMAX, 'h1014, '0, 20, 1'b0);
        add_entry(OP_WIRQ, '0, 'b10, 'b10, 1'b0);
        // Count read after the first wrap
        add_entry(OP_RDMAX, 'h1014, '0, 20, 1'b0);
        add_entry(OP_RD, 'h101C, '0, 1, 1'b0);
        add_entry(OP_RD, 'h404, '0, 5, 1'b0);
        add_entry(OP_IRQ, '0, 'b10, 'b00, 1'b0);
        add_entry(OP_WR, 'h101C, 1, '0, 1'b0);
        add_entry(OP_WR, 'h404, 5, '0, 1'b0);
        add_entry(OP_IRQ, '0, 'b10, 'b00, 1'b0);
    endtask

    initial begin
        entry_t    e;
        apb_data_t rdata;
        logic      err;
        int        total;
        rst_n_i   = 1'b0;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        irq_src_i = '0;
        rdata     = '0;
        err       = 1'b0;
        void'($urandom(32'h7f1a62a2));
        build_table();
        total = RESET_CYCLES;
        foreach (stim_q[n]) begin
            total += (stim_q[n].op == OP_WIRQ) ? IRQ_WAIT + 1 : 3;
        end
        cycle_limit = 4 * total;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;

        // ----------------------------------------------------------
        // Apply the table
        // ----------------------------------------------------------
        foreach (stim_q[n]) begin
            e = stim_q[n];
            case (e.op)
                OP_WR, OP_RD, OP_RDMAX: begin
                    apb_access(e.op == OP_WR, e.addr, e.data, rdata, err);
                    check_value("pslverr_o", apb_data_t'(err), apb_data_t'(e.err));
                    if (e.op == OP_RD) begin
                        check_value("prdata_o", rdata, e.exp);
                    end else if (e.op == OP_RDMAX) begin
                        check_value("prdata_o <= bound", apb_data_t'(rdata <= e.exp), 'd1);
                    end
                end
                OP_SRC: begin
                    @(posedge clk_i);
                    irq_src_i <= e.data[2:0];
                end
                OP_IRQ: begin
                    // Allow one cycle for a source to pend again
                    repeat (2) @(negedge clk_i);
                    check_value("irq_o", apb_data_t'(irq_o & e.data[1:0]), e.exp);
                end
                default: wait_for_irq(e.data[1:0], e.exp[1:0]);
            endcase
        end
        @(posedge clk_i);
        $display("all tests passed");
        $finish;
    end

endmodule

// File: filelist.f
periph_pkg.sv
timer_channel.sv
apb_timer.sv
plic_gateway.sv
plic_target.sv
plic_core.sv
apb_decoder.sv
periph_top.sv
periph_checker.sv
tb_periph_top.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_periph_top \
    -f filelist.f -o sim_periph \
    && ./obj_dir/sim_periph \
    || { echo "simulation returned an error"; exit 1; }
